// File: files.f
hdl/mmio_pkg.sv
hdl/csr_map_pkg.sv
hdl/mmio_req_split.sv
hdl/afu_csr_rd.sv
hdl/afu_user_regs.sv
hdl/mmio_rsp_arb.sv
hdl/csr_subsystem.sv
bench/csr_subsystem_chk.sv
bench/csr_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the CSR subsystem testbench

.PHONY: all run lint clean

all: run

obj_dir/Vcsr_subsystem_tb: files.f hdl/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module csr_subsystem_tb -o Vcsr_subsystem_tb

# The log decides pass or fail
run: obj_dir/Vcsr_subsystem_tb
	./obj_dir/Vcsr_subsystem_tb | tee sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f files.f \
		--top-module csr_subsystem_tb

clean:
	rm -rf obj_dir sim.log

// File: bench/csr_subsystem_tb.sv
// Testbench for the MMIO control-register subsystem
// Reset, header, user, SREG and mixed traffic against a reference model

`timescale 1ns/1ps

module csr_subsystem_tb;

    logic                             clk;
    logic                             reset_n;
    mmio_pkg::t_mmio_req              host_req;
    mmio_pkg::t_mmio_rsp              host_rsp;
    csr_map_pkg::t_sreg_req           sreg_req      [csr_map_pkg::NUM_FUNC];
    logic [csr_map_pkg::NUM_FUNC-1:0] sreg_rsp_valid;
    logic [63:0]                      sreg_rsp_data [csr_map_pkg::NUM_FUNC];

    // Reference state updated in issue order
    bit [63:0]   user_model [csr_map_pkg::NUM_FUNC][16];
    bit [7:0]    idx_model  [csr_map_pkg::NUM_FUNC];
    bit          sreg_busy  [csr_map_pkg::NUM_FUNC];

    // Scoreboard entries indexed by tid
    bit          exp_pending [512];
    bit          exp_fixed   [512];
    logic [63:0] exp_data    [512];
    int          exp_cycle   [512];
    int          exp_func    [512];

    // SREG store countdown per function
    // Delays are drawn once at the start of the run
    int          store_wait [csr_map_pkg::NUM_FUNC];
    logic [7:0]  store_idx  [csr_map_pkg::NUM_FUNC];
    int          delay_tab  [256];
    int          delay_ptr;

    int          cycle;
    int          issued;
    int          outstanding;
    int          check_count;
    int          error_count;

    csr_subsystem dut_i
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req       (host_req),
        .host_rsp       (host_rsp),
        .sreg_req       (sreg_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    bind csr_subsystem csr_subsystem_chk chk_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .func_req (func_req),
        .sreg_req (sreg_req),
        .held_rsp (held_rsp)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // SREG contents as a fixed scramble of function and index
    function automatic logic [63:0] sreg_value(input int func, input logic [7:0] idx);
        return {8'(func) ^ 8'h5a, idx, 48'h0} ^ ({56'h0, idx} * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    // Expected read data from the register map and the models
    function automatic logic [63:0] expected_read(input int func, input logic [4:0] ofs);
        logic [127:0] afu_id;
        afu_id = csr_map_pkg::AFU_ID_TABLE[func];
        if (ofs >= csr_map_pkg::OFS_USER)
            return user_model[func][4'(ofs - csr_map_pkg::OFS_USER)];
        case (ofs)
            csr_map_pkg::OFS_DFH:
                return {csr_map_pkg::DFH_AFU_TYPE, 19'h0, 1'b1, 24'h0, 4'h0, 12'(func)};
            csr_map_pkg::OFS_ID_L:      return afu_id[63:0];
            csr_map_pkg::OFS_ID_H:      return afu_id[127:64];
            csr_map_pkg::OFS_SREG_READ: return sreg_value(func, idx_model[func]);
            default:                    return 64'h0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Valids that must be low in and right after reset
    task automatic check_outputs_quiet();
        check_value("host_rsp.valid", 64'(host_rsp.valid), 64'h0);
        for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
            check_value("sreg_req.valid", 64'(sreg_req[f].valid), 64'h0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    // One request in the next cycle
    // Upper address bits are random since the DUT does not decode them
    task automatic send(input int func, input logic [4:0] ofs, input bit rd,
                        input logic [63:0] wdata);
        mmio_pkg::t_mmio_tid tid;
        @(posedge clk);
        #1;
        tid = mmio_pkg::t_mmio_tid'(issued);
        host_req.valid   = 1'b1;
        host_req.is_read = rd;
        host_req.addr    = {9'($urandom), 2'(func), ofs};
        host_req.tid     = tid;
        host_req.data    = wdata;
        issued++;
        if (rd)
        begin
            exp_pending[tid] = 1'b1;
            exp_fixed[tid]   = (ofs != csr_map_pkg::OFS_SREG_READ);
            exp_data[tid]    = expected_read(func, ofs);
            exp_cycle[tid]   = cycle;
            exp_func[tid]    = func;
            outstanding++;
            if (ofs == csr_map_pkg::OFS_SREG_READ)
                sreg_busy[func] = 1'b1;
        end
        else if (ofs >= csr_map_pkg::OFS_USER)
            user_model[func][4'(ofs - csr_map_pkg::OFS_USER)] = wdata;
        else if (ofs == csr_map_pkg::OFS_SREG_ADDR)
            idx_model[func] = wdata[7:0];
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            host_req.valid = 1'b0;
        end
    endtask

    // Wait until every read has its response
    task automatic drain();
        idle(1);
        while (outstanding > 0)
            idle(1);
    endtask

    // SREG store answers each pulse after its drawn delay
    always @(posedge clk)
    begin
        #1;
        for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
        begin
            sreg_rsp_valid[f] = 1'b0;
            if (store_wait[f] > 0)
            begin
                store_wait[f]--;
                if (store_wait[f] == 0)
                begin
                    sreg_rsp_valid[f] = 1'b1;
                    sreg_rsp_data[f]  = sreg_value(f, store_idx[f]);
                end
            end
            if (sreg_req[f].valid === 1'b1)
            begin
                store_idx[f]  = sreg_req[f].idx;
                store_wait[f] = delay_tab[delay_ptr];
                delay_ptr     = (delay_ptr + 1) % 256;
            end
        end
    end

    // Cycle count and run limit
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > 20 * issued + 200)
        begin
            $display("timeout after %0d cycles, %0d reads unanswered", cycle, outstanding);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Scoreboard compare at the falling edge
    always @(negedge clk)
    begin
        mmio_pkg::t_mmio_tid t;
        t = host_rsp.tid;
        if (reset_n && host_rsp.valid)
        begin
            if (!exp_pending[t])
            begin
                $display("unexpected response with tid %0d at %0t ns", t, $time);
                error_count++;
            end
            else
            begin
                check_value("read data", host_rsp.data.raw, exp_data[t]);
                // SREG reads have no fixed latency and free their function instead
                if (exp_fixed[t])
                    check_value("read latency", 64'(cycle - exp_cycle[t]), 64'd3);
                else
                    sreg_busy[exp_func[t]] = 1'b0;
                exp_pending[t] = 1'b0;
                outstanding--;
            end
        end
    end

    initial
    begin
        int start;
        int func;
        int r;
        clk            = 1'b0;
        reset_n        = 1'b0;
        host_req       = '0;
        sreg_rsp_valid = '0;
        foreach (sreg_rsp_data[f])
            sreg_rsp_data[f] = 64'h0;
        void'($urandom(32'ha4f5_dd25));
        foreach (delay_tab[i])
            delay_tab[i] = $urandom_range(12, 1);

        // Reset held for 10 edges
        // Outputs stay quiet through the first edge after it
        start = error_count;
        repeat (9)
        begin
            @(negedge clk);
            check_outputs_quiet();
        end
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            check_outputs_quiet();
        end
        report_test("reset", start);

        // Every header word of every function except the SREG read offset
        start = error_count;
        for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
            for (int o = 0; o < 16; o++)
                if (o != int'(csr_map_pkg::OFS_SREG_READ))
                    send(f, 5'(o), 1'b1, 64'h0);
        drain();
        report_test("header", start);

        // Random subset of user registers written and all of them read back
        start = error_count;
        for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
            for (int u = 0; u < 16; u++)
                if ($urandom_range(3, 0) != 0)
                    send(f, 5'(16 + u), 1'b0, {$urandom, $urandom});
        for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
            for (int u = 0; u < 16; u++)
                send(f, 5'(16 + u), 1'b1, 64'h0);
        drain();
        report_test("user", start);

        // All functions hold an SREG result at once and round-robin drains them
        start = error_count;
        repeat (3)
        begin
            for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
                send(f, csr_map_pkg::OFS_SREG_ADDR, 1'b0, 64'($urandom));
            for (int f = 0; f < int'(csr_map_pkg::NUM_FUNC); f++)
                send(f, csr_map_pkg::OFS_SREG_READ, 1'b1, 64'h0);
            drain();
        end
        report_test("sreg", start);

        // Random back-to-back traffic with at most one SREG read per function
        start = error_count;
        repeat (300)
        begin
            func = $urandom_range(3, 0);
            r    = $urandom_range(15, 0);
            case ($urandom_range(9, 0))
                0, 1, 2: send(func, 5'(16 + r), 1'b0, {$urandom, $urandom});
                3, 4, 5: send(func, 5'(16 + r), 1'b1, 64'h0);
                6:       send(func, 5'((r == 12) ? 0 : r), 1'b1, 64'h0);
                7:       send(func, csr_map_pkg::OFS_SREG_ADDR, 1'b0, 64'($urandom));
                8:
                begin
                    if (sreg_busy[func])
                        send(func, csr_map_pkg::OFS_DFH, 1'b1, 64'h0);
                    else
                        send(func, csr_map_pkg::OFS_SREG_READ, 1'b1, 64'h0);
                end
                default: idle(1);
            endcase
        end
        drain();
        report_test("mixed", start);

        $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, dut_i.chk_i.fail_count);
        if (error_count == 0 && dut_i.chk_i.fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: bench/csr_subsystem_chk.sv
// Protocol checker for the CSR subsystem
// Reset quiet, one split request per cycle, one SREG read per function

`timescale 1ns/1ps

module csr_subsystem_chk
(
    input logic                   clk,
    input logic                   reset_n,
    input mmio_pkg::t_mmio_req    host_req,
    input mmio_pkg::t_mmio_rsp    host_rsp,
    input mmio_pkg::t_mmio_req    func_req [csr_map_pkg::NUM_FUNC],
    input csr_map_pkg::t_sreg_req sreg_req [csr_map_pkg::NUM_FUNC],
    input mmio_pkg::t_mmio_rsp    held_rsp [csr_map_pkg::NUM_FUNC]
);

    // Number of failed assertions
    int fail_count = 0;
    logic [csr_map_pkg::NUM_FUNC-1:0] split_valid;
    // Slot addressed by the host request of this cycle
    logic [csr_map_pkg::NUM_FUNC-1:0] host_slot;

    always_comb
    begin
        for (int i = 0; i < int'(csr_map_pkg::NUM_FUNC); i++)
            split_valid[i] = func_req[i].valid;
    end

    always_comb
    begin
        host_slot = '0;
        if (host_req.valid)
            host_slot[host_req.addr[6:5]] = 1'b1;
    end

    // Response register cleared by every reset edge
    a_rsp_in_reset: assert property (@(posedge clk) !reset_n |=> !host_rsp.valid)
    else
    begin
        fail_count++;
        $error("host response valid while reset is held");
    end

    // Each request lands only in the slot its address bits 6:5 name
    a_split_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(split_valid) && (split_valid == $past(host_slot)))
    else
    begin
        fail_count++;
        $error("split requests do not match the slot of the host request");
    end

    // New SREG pulse only once the held result has gone out
    for (genvar g = 0; g < csr_map_pkg::NUM_FUNC; g++)
    begin : g_sreg
        a_sreg_single: assert property (@(posedge clk) disable iff (!reset_n)
            held_rsp[g].valid |-> !sreg_req[g].valid)
        else
        begin
            fail_count++;
            $error("second SREG request while a held response is pending");
        end
    end

endmodule

// File: hdl/csr_subsystem.sv
// MMIO control-register subsystem
// Splits host requests over the function slots and merges their responses

`timescale 1ns/1ps

module csr_subsystem
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  mmio_pkg::t_mmio_req              host_req,
    output mmio_pkg::t_mmio_rsp              host_rsp,
    output csr_map_pkg::t_sreg_req           sreg_req       [csr_map_pkg::NUM_FUNC],
    input  logic [csr_map_pkg::NUM_FUNC-1:0] sreg_rsp_valid,
    input  logic [63:0]                      sreg_rsp_data  [csr_map_pkg::NUM_FUNC]
);

    // Per-slot request and response paths
    mmio_pkg::t_mmio_req              func_req   [csr_map_pkg::NUM_FUNC];
    mmio_pkg::t_mmio_req              user_req   [csr_map_pkg::NUM_FUNC];
    mmio_pkg::t_mmio_rsp              user_rsp   [csr_map_pkg::NUM_FUNC];
    mmio_pkg::t_mmio_rsp              direct_rsp [csr_map_pkg::NUM_FUNC];
    mmio_pkg::t_mmio_rsp              held_rsp   [csr_map_pkg::NUM_FUNC];
    logic [csr_map_pkg::NUM_FUNC-1:0] sreg_grant;

    // Request decode and first register stage
    mmio_req_split split_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .host_req (host_req),
        .func_req (func_req)
    );

    // One header shim and one user block per function
    for (genvar g = 0; g < csr_map_pkg::NUM_FUNC; g++)
    begin : g_func
        afu_csr_rd
        #(
            .FUNC_ID (g)
        )
        csr_rd_i
        (
            .clk            (clk),
            .reset_n        (reset_n),
            .req            (func_req[g]),
            .user_req       (user_req[g]),
            .user_rsp       (user_rsp[g]),
            .direct_rsp     (direct_rsp[g]),
            .sreg_req       (sreg_req[g]),
            .sreg_rsp_valid (sreg_rsp_valid[g]),
            .sreg_rsp_data  (sreg_rsp_data[g]),
            .held_rsp       (held_rsp[g]),
            .sreg_grant     (sreg_grant[g])
        );

        afu_user_regs user_regs_i
        (
            .clk     (clk),
            .reset_n (reset_n),
            .req     (user_req[g]),
            .rsp     (user_rsp[g])
        );
    end

    // Merge into the single host response channel
    mmio_rsp_arb arb_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .direct_rsp (direct_rsp),
        .held_rsp   (held_rsp),
        .sreg_grant (sreg_grant),
        .host_rsp   (host_rsp)
    );

endmodule

// File: hdl/mmio_rsp_arb.sv
// MMIO response arbiter
// Direct responses go first, held SREG responses fill free cycles round-robin

`timescale 1ns/1ps

module mmio_rsp_arb
(
    input  logic                              clk,
    input  logic                              reset_n,
    input  mmio_pkg::t_mmio_rsp               direct_rsp [csr_map_pkg::NUM_FUNC],
    input  mmio_pkg::t_mmio_rsp               held_rsp   [csr_map_pkg::NUM_FUNC],
    output logic [csr_map_pkg::NUM_FUNC-1:0]  sreg_grant,
    output mmio_pkg::t_mmio_rsp               host_rsp
);

    // Slot with the highest SREG priority next time
    csr_map_pkg::t_func_idx rr_ptr;
    csr_map_pkg::t_func_idx cand;
    csr_map_pkg::t_func_idx grant_idx;
    logic                   any_direct;
    logic                   grant_hit;
    mmio_pkg::t_mmio_rsp    direct_sel;
    mmio_pkg::t_mmio_rsp    rsp_d;

    // At most one direct response per cycle, since the host issues one request
    always_comb
    begin
        any_direct = 1'b0;
        direct_sel = '0;
        for (int i = 0; i < csr_map_pkg::NUM_FUNC; i++)
        begin
            if (direct_rsp[i].valid)
            begin
                any_direct = 1'b1;
                direct_sel = direct_rsp[i];
            end
        end
    end

    // First held response at or after the pointer
    // Slot index wraps naturally, NUM_FUNC is a power of two
    always_comb
    begin
        grant_hit = 1'b0;
        grant_idx = rr_ptr;
        cand      = rr_ptr;
        for (int i = 0; i < csr_map_pkg::NUM_FUNC; i++)
        begin
            cand = rr_ptr + csr_map_pkg::t_func_idx'(i);
            if (!grant_hit && held_rsp[cand].valid)
            begin
                grant_hit = 1'b1;
                grant_idx = cand;
            end
        end
    end

    // Grant only in a cycle no direct response uses
    always_comb
    begin
        for (int i = 0; i < csr_map_pkg::NUM_FUNC; i++)
        begin
            sreg_grant[i] = !any_direct && grant_hit &&
                            (grant_idx == csr_map_pkg::t_func_idx'(i));
        end
    end

    always_comb
    begin
        rsp_d = held_rsp[grant_idx];
        rsp_d.valid = grant_hit;
        if (any_direct)
            rsp_d = direct_sel;
    end

    // Output register and pointer update
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            host_rsp.valid <= 1'b0;
            rr_ptr         <= '0;
        end
        else
        begin
            host_rsp.valid <= rsp_d.valid;
            if (!any_direct && grant_hit)
                rr_ptr <= grant_idx + 1'b1;
        end
        host_rsp.tid  <= rsp_d.tid;
        host_rsp.data <= rsp_d.data;
    end

endmodule

// File: hdl/afu_user_regs.sv
// User register block of one accelerator function
// Sixteen 64-bit read/write registers above the header area

`timescale 1ns/1ps

module afu_user_regs
(
    input  logic                clk,
    input  logic                reset_n,
    input  mmio_pkg::t_mmio_req req,
    output mmio_pkg::t_mmio_rsp rsp
);

    logic [63:0] regs [csr_map_pkg::NUM_USER_REGS];
    logic [3:0]  reg_idx;
    logic        wr_en;
    logic        rd_en;

    // Register index relative to the start of the user area
    assign reg_idx = 4'(req.addr[4:0] - csr_map_pkg::OFS_USER);

    assign wr_en = req.valid && !req.is_read;
    assign rd_en = req.valid && req.is_read;

    // Register file, cleared by reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < csr_map_pkg::NUM_USER_REGS; i++)
            begin
                regs[i] <= 64'h0;
            end
        end
        else if (wr_en)
        begin
            regs[reg_idx] <= req.data;
        end
    end

    // Read response one cycle after the request
    // A write and a read never share a cycle, so no bypass is needed
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rsp.valid <= 1'b0;
        else
            rsp.valid <= rd_en;
        rsp.tid      <= req.tid;
        rsp.data.raw <= regs[reg_idx];
    end

endmodule

// File: hdl/afu_csr_rd.sv
// Header-register shim of one accelerator function
// Answers DFH and ID reads, runs the indirect SREG read, forwards user-area requests

`timescale 1ns/1ps

module afu_csr_rd
#(
    parameter int unsigned FUNC_ID = 0
)
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  mmio_pkg::t_mmio_req    req,
    output mmio_pkg::t_mmio_req    user_req,
    input  mmio_pkg::t_mmio_rsp    user_rsp,
    output mmio_pkg::t_mmio_rsp    direct_rsp,
    output csr_map_pkg::t_sreg_req sreg_req,
    input  logic                   sreg_rsp_valid,
    input  logic [63:0]            sreg_rsp_data,
    output mmio_pkg::t_mmio_rsp    held_rsp,
    input  logic                   sreg_grant
);

    logic [4:0]            ofs;
    logic                  is_user;
    logic                  hdr_rd;
    logic                  sreg_rd;
    logic                  idx_wr;
    mmio_pkg::t_mmio_data  hdr_data;
    mmio_pkg::t_mmio_rsp   hdr_rsp_q;
    mmio_pkg::t_mmio_rsp   held_q;
    mmio_pkg::t_mmio_tid   sreg_tid;
    logic [7:0]            sreg_idx;

    // Local word offset, already reduced by the splitter
    assign ofs     = req.addr[4:0];
    assign is_user = (ofs >= csr_map_pkg::OFS_USER);

    // Request decode
    assign hdr_rd  = req.valid && req.is_read && !is_user;
    assign sreg_rd = hdr_rd && (ofs == csr_map_pkg::OFS_SREG_READ);
    assign idx_wr  = req.valid && !req.is_read && (ofs == csr_map_pkg::OFS_SREG_ADDR);

    // User area passes straight through to the register block
    always_comb
    begin
        user_req = req;
        user_req.valid = req.valid && is_user;
    end

    // Header read data
    // Anything not listed, reserved words included, reads as zero
    always_comb
    begin
        hdr_data.raw = '0;
        case (ofs)
            csr_map_pkg::OFS_DFH:
            begin
                hdr_data.dfh.feature_type = csr_map_pkg::DFH_AFU_TYPE;
                hdr_data.dfh.eol          = 1'b1;
                hdr_data.dfh.next_ofs     = '0;
                hdr_data.dfh.revision     = '0;
                hdr_data.dfh.feature_id   = 12'(FUNC_ID);
            end
            csr_map_pkg::OFS_ID_L: hdr_data.raw = csr_map_pkg::AFU_ID_TABLE[FUNC_ID][63:0];
            csr_map_pkg::OFS_ID_H: hdr_data.raw = csr_map_pkg::AFU_ID_TABLE[FUNC_ID][127:64];
            default: ;
        endcase
    end

    // Header response one cycle after the request
    // SREG reads answer later through the held path
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            hdr_rsp_q.valid <= 1'b0;
        else
            hdr_rsp_q.valid <= hdr_rd && !sreg_rd;
        hdr_rsp_q.tid  <= req.tid;
        hdr_rsp_q.data <= hdr_data;
    end

    // Own response and user response never overlap
    assign direct_rsp = hdr_rsp_q.valid ? hdr_rsp_q : user_rsp;

    // SREG index written by the host ahead of the read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sreg_idx <= 8'h00;
        else if (idx_wr)
            sreg_idx <= req.data[7:0];
    end

    // Request pulse toward the SREG store
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sreg_req.valid <= 1'b0;
        else
            sreg_req.valid <= sreg_rd;
        sreg_req.idx <= sreg_idx;
    end

    // Tid of the one outstanding SREG read
    always_ff @(posedge clk)
    begin
        if (sreg_rd)
            sreg_tid <= req.tid;
    end

    // Hold the SREG result until the arbiter finds a free cycle
    // Host never overlaps two reads, so grant and a new result cannot collide
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            held_q.valid <= 1'b0;
        end
        else if (sreg_grant)
        begin
            held_q.valid <= 1'b0;
        end
        else if (sreg_rsp_valid)
        begin
            held_q.valid    <= 1'b1;
            held_q.tid      <= sreg_tid;
            held_q.data.raw <= sreg_rsp_data;
        end
    end

    assign held_rsp = held_q;

endmodule

// File: hdl/mmio_req_split.sv
// MMIO request splitter
// Registers each host request and steers it to one function slot

`timescale 1ns/1ps

module mmio_req_split
(
    input  logic                clk,
    input  logic                reset_n,
    input  mmio_pkg::t_mmio_req host_req,
    output mmio_pkg::t_mmio_req func_req [csr_map_pkg::NUM_FUNC]
);

    // Function select from address bits 6:5
    csr_map_pkg::t_func_idx func_sel;

    // Request with the address reduced to the local word offset
    mmio_pkg::t_mmio_req    local_req;

    assign func_sel = host_req.addr[6:5];

    always_comb
    begin
        local_req = host_req;
        // Upper address bits are not decoded, drop them here
        local_req.addr = mmio_pkg::t_mmio_addr'(host_req.addr[4:0]);
    end

    // One register stage per slot
    // Every slot sees the payload, only the addressed one sees valid
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < csr_map_pkg::NUM_FUNC; i++)
        begin
            if (!reset_n)
            begin
                func_req[i].valid <= 1'b0;
            end
            else
            begin
                func_req[i].valid <= host_req.valid &&
                                     (func_sel == csr_map_pkg::t_func_idx'(i));
            end

            func_req[i].is_read <= local_req.is_read;
            func_req[i].addr    <= local_req.addr;
            func_req[i].tid     <= local_req.tid;
            func_req[i].data    <= local_req.data;
        end
    end

endmodule

// File: hdl/csr_map_pkg.sv
// Control-register map of one accelerator function
// Function count, header word offsets, ID table and the SREG request record

package csr_map_pkg;

    // Function slots behind the one host link
    // NUM_FUNC must stay equal to 2**FUNC_IDX_W
    localparam logic [2:0] NUM_FUNC   = 3'd4;
    localparam int         FUNC_IDX_W = 2;

    // Index of one function slot
    typedef logic [FUNC_IDX_W-1:0] t_func_idx;

    // Header word offsets inside one function
    localparam logic [4:0] OFS_DFH       = 5'd0;
    localparam logic [4:0] OFS_ID_L      = 5'd2;
    localparam logic [4:0] OFS_ID_H      = 5'd4;
    localparam logic [4:0] OFS_RSVD0     = 5'd6;
    localparam logic [4:0] OFS_RSVD1     = 5'd8;
    localparam logic [4:0] OFS_SREG_ADDR = 5'd10;
    localparam logic [4:0] OFS_SREG_READ = 5'd12;

    // User area starts here and runs to the end of the window
    localparam logic [4:0] OFS_USER      = 5'd16;
    localparam int         NUM_USER_REGS = 16;

    // Feature type code of an accelerator
    localparam logic [3:0] DFH_AFU_TYPE = 4'h1;

    // 128-bit accelerator ID per function, low word read at ID_L
    localparam logic [127:0] AFU_ID_TABLE [NUM_FUNC] = '{
        128'h3c1e_77a0_49d2_4b8f_a615_02c9_e4d8_5b13,
        128'h9f04_2be6_d381_46a7_8c3d_f170_6a29_e05c,
        128'h51d8_c0f3_7e6a_4195_b2e4_8d17_0c6f_a932,
        128'he7a2_5946_18bc_4fd0_9e71_3b58_c2a4_07f6
    };

    // Indirect system-register read, valid pulses for one cycle
    typedef struct packed
    {
        logic       valid;
        logic [7:0] idx;
    } t_sreg_req;

endpackage

// File: hdl/mmio_pkg.sv
// MMIO host-link types
// Request, response, transaction ID and the two views of a response data word

package mmio_pkg;

    // Host transaction ID, echoed back on every read response
    typedef logic [8:0] t_mmio_tid;

    // MMIO word address
    // Only bits 6:0 are decoded, 6:5 pick the function and 4:0 the local word
    typedef logic [15:0] t_mmio_addr;

    // Device feature header as seen by host software
    typedef struct packed
    {
        logic [3:0]  feature_type;
        logic [18:0] rsvd;
        logic        eol;
        logic [23:0] next_ofs;
        logic [3:0]  revision;
        logic [11:0] feature_id;
    } t_dfh;

    // Response data word
    // Plain 64-bit value for most registers, DFH record for offset 0
    typedef union packed
    {
        logic [63:0] raw;
        t_dfh        dfh;
    } t_mmio_data;

    // Host request, one per cycle at most
    // Writes carry data, reads ignore it
    typedef struct packed
    {
        logic        valid;
        logic        is_read;
        t_mmio_addr  addr;
        t_mmio_tid   tid;
        logic [63:0] data;
    } t_mmio_req;

    // Read response back to the host
    typedef struct packed
    {
        logic       valid;
        t_mmio_tid  tid;
        t_mmio_data data;
    } t_mmio_rsp;

endpackage
